/* design/vseq_isa_pkg.sv */
// Instruction-set types shared by the dispatcher side of the sequencer and its testbench
`default_nettype none

package vseq_isa_pkg;

  // Lane ops first, then mask unit ops, then memory ops
  typedef enum logic [2:0] {
    VADD,
    VMUL,
    VREDSUM,
    VMAND,
    VMOR,
    VLE,
    VSE
  } vop_e;

  // Element width
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } eew_e;

  typedef logic [4:0]  vreg_t;
  typedef logic [31:0] elen_t;

  // Register that holds the mask
  localparam vreg_t VMASK = 5'd0;

  // Decoded instruction from the dispatcher
  typedef struct packed {
    vop_e       op;
    logic       vm;         // Unmasked when set
    vreg_t      vs1;
    logic       use_vs1;
    vreg_t      vs2;
    logic       use_vs2;
    vreg_t      vd;
    logic       use_vd;
    elen_t      scalar_op;  // Base address for loads and stores
    eew_e       eew;
    logic [7:0] vl;
  } vseq_req_t;

  typedef struct packed {
    elen_t resp;
    logic  error;
  } vseq_resp_t;

endpackage

`default_nettype wire

/* design/vseq_uarch_pkg.sv */
// Microarchitecture types shared by the sequencer, the id allocator and the processing elements
`default_nettype none

package vseq_uarch_pkg;

  import vseq_isa_pkg::*;

  // Instructions in flight at once
  localparam int unsigned NrVInsn = 4;
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;

  // Unit that executes an op
  typedef enum logic [1:0] {
    VFU_Lane,
    VFU_Load,
    VFU_Store,
    VFU_Mask
  } vfu_e;

  // PE index of each unit, counted after the lanes
  localparam int unsigned OffsetLoad  = 0;
  localparam int unsigned OffsetStore = 1;
  localparam int unsigned OffsetMask  = 2;

  typedef struct packed {
    vid_t               id;
    vop_e               op;
    vfu_e               vfu;
    logic               vm;
    logic [7:0]         vl;
    eew_e               eew;
    elen_t              scalar_op;
    logic [NrVInsn-1:0] vinsn_running;
    // Ids that must retire before the operands may be touched
    logic [NrVInsn-1:0] hazard_vs1;
    logic [NrVInsn-1:0] hazard_vs2;
    logic [NrVInsn-1:0] hazard_vm;
    logic [NrVInsn-1:0] hazard_vd;
  } pe_req_t;

  typedef struct packed {
    logic [NrVInsn-1:0] vinsn_done;  // One-hot, one cycle
  } pe_resp_t;

endpackage

`default_nettype wire

/* design/vinsn_id_alloc.sv */
// Tracks which ids run on which PE, hands out the lowest free id and reports retirements
`timescale 1ns/1ps
`default_nettype none

module vinsn_id_alloc import vseq_uarch_pkg::*; #(
  parameter int unsigned NrPEs = 5
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          alloc_i,
  input  vid_t                          alloc_id_i,
  input  logic [NrPEs-1:0]              alloc_pe_mask_i,
  input  pe_resp_t [NrPEs-1:0]          pe_resp_i,
  output vid_t                          next_id_o,
  output logic                          full_o,
  output logic [NrVInsn-1:0]            running_o,
  output logic [NrVInsn-1:0]            running_next_o,
  output logic [NrPEs-1:0][NrVInsn-1:0] pe_running_o,
  output logic [NrVInsn-1:0]            retired_o
);

  logic [NrPEs-1:0][NrVInsn-1:0] pe_running_d, pe_running_q;

  always_comb begin
    running_o      = '0;
    running_next_o = '0;
    for (int unsigned pe = 0; pe < NrPEs; pe++) begin
      // Done pulses clear first, the new id is added on top
      pe_running_d[pe] = pe_running_q[pe] & ~pe_resp_i[pe].vinsn_done;
      running_o       |= pe_running_q[pe];
      running_next_o  |= pe_running_d[pe];
      if (alloc_i && alloc_pe_mask_i[pe]) begin
        pe_running_d[pe][alloc_id_i] = 1'b1;
      end
    end
  end

  // Leading-zero search from the top, so the lowest free index wins
  always_comb begin
    next_id_o = '0;
    for (int i = NrVInsn - 1; i >= 0; i--) begin
      if (!running_o[i]) begin
        next_id_o = vid_t'(i);
      end
    end
  end

  assign full_o       = &running_o;
  assign pe_running_o = pe_running_q;
  // Ids whose last running bit clears this cycle
  assign retired_o    = running_o & ~running_next_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pe_running_q <= '0;
    end else begin
      pe_running_q <= pe_running_d;
    end
  end

  // The sequencer must only ever issue with a free id
  assert property (@(posedge clk_i) disable iff (!rst_ni) alloc_i |-> !running_o[alloc_id_i]);

endmodule

`default_nettype wire

/* design/vreg_scoreboard.sv */
// Per-register reader and writer ownership, giving RAW, WAR and WAW hazard masks at issue
`timescale 1ns/1ps
`default_nettype none

module vreg_scoreboard import vseq_isa_pkg::*; import vseq_uarch_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               issue_i,
  input  vid_t               issue_id_i,
  input  vseq_req_t          req_i,
  input  logic [NrVInsn-1:0] running_i,
  output logic [NrVInsn-1:0] haz_vs1_o,
  output logic [NrVInsn-1:0] haz_vs2_o,
  output logic [NrVInsn-1:0] haz_vm_o,
  output logic [NrVInsn-1:0] haz_vd_o
);

  typedef struct packed {
    vid_t vid;
    logic valid;
  } vreg_access_t;

  vreg_access_t [31:0] read_list_d, read_list_q;
  vreg_access_t [31:0] write_list_d, write_list_q;

  // One-hot id of the current owner, empty when there is none
  function automatic logic [NrVInsn-1:0] owner(vreg_access_t e);
    owner        = '0;
    owner[e.vid] = e.valid;
  endfunction

  always_comb begin
    // Entries of retired ids drop out
    for (int unsigned v = 0; v < 32; v++) begin
      read_list_d[v]        = read_list_q[v];
      write_list_d[v]       = write_list_q[v];
      read_list_d[v].valid  = read_list_q[v].valid & running_i[read_list_q[v].vid];
      write_list_d[v].valid = write_list_q[v].valid & running_i[write_list_q[v].vid];
    end

    // RAW on both sources and on the mask
    haz_vs1_o = req_i.use_vs1 ? owner(write_list_d[req_i.vs1]) : '0;
    haz_vs2_o = req_i.use_vs2 ? owner(write_list_d[req_i.vs2]) : '0;
    haz_vm_o  = !req_i.vm ? owner(write_list_d[VMASK]) : '0;
    haz_vd_o  = '0;

    if (req_i.use_vd) begin
      // WAR, the last reader of vd must be done with it
      haz_vs1_o |= owner(read_list_d[req_i.vd]);
      haz_vs2_o |= owner(read_list_d[req_i.vd]);
      haz_vm_o  |= owner(read_list_d[req_i.vd]);
      // WAW
      haz_vd_o  |= owner(write_list_d[req_i.vd]);
    end

    // New instruction becomes the owner of its registers
    if (issue_i) begin
      if (req_i.use_vd) begin
        write_list_d[req_i.vd] = '{vid: issue_id_i, valid: 1'b1};
      end
      if (req_i.use_vs1) begin
        read_list_d[req_i.vs1] = '{vid: issue_id_i, valid: 1'b1};
      end
      if (req_i.use_vs2) begin
        read_list_d[req_i.vs2] = '{vid: issue_id_i, valid: 1'b1};
      end
      if (!req_i.vm) begin
        read_list_d[VMASK] = '{vid: issue_id_i, valid: 1'b1};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_list_q  <= '0;
      write_list_q <= '0;
    end else begin
      read_list_q  <= read_list_d;
      write_list_q <= write_list_d;
    end
  end

endmodule

`default_nettype wire

/* design/vseq_sequencer.sv */
// Control FSM that accepts dispatcher requests, issues them to the PEs and returns responses
`timescale 1ns/1ps
`default_nettype none

module vseq_sequencer import vseq_isa_pkg::*; import vseq_uarch_pkg::*; #(
  parameter int unsigned NrLanes = 2,
  parameter int unsigned NrPEs   = NrLanes + 3
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Dispatcher
  input  vseq_req_t                     req_i,
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  output vseq_resp_t                    resp_o,
  output logic                          resp_valid_o,
  // Id allocator and scoreboard
  input  logic [NrPEs-1:0]              pe_ready_i,
  input  vid_t                          next_id_i,
  input  logic                          full_i,
  input  logic [NrPEs-1:0][NrVInsn-1:0] pe_running_i,
  input  logic [NrVInsn-1:0]            running_next_i,
  input  logic [NrVInsn-1:0]            haz_vs1_i,
  input  logic [NrVInsn-1:0]            haz_vs2_i,
  input  logic [NrVInsn-1:0]            haz_vm_i,
  input  logic [NrVInsn-1:0]            haz_vd_i,
  // Address check and lane 0 scalar result
  input  logic                          addr_ack_i,
  input  logic                          addr_error_i,
  input  elen_t                         scalar_i,
  input  logic                          scalar_valid_i,
  output logic                          alloc_o,
  output logic [NrPEs-1:0]              alloc_pe_mask_o,
  output logic                          issue_o,
  output pe_req_t                       pe_req_o,
  output logic                          pe_req_valid_o
);

  typedef enum logic {
    IDLE,
    WAIT
  } state_e;

  state_e  state_d, state_q;
  pe_req_t pe_req_d;
  logic    pe_req_valid_d;
  vfu_e    req_vfu;
  logic    struct_hazard, accept, wait_op, mem_op;

  function automatic vfu_e vfu(vop_e op);
    case (op)
      VMAND, VMOR: vfu = VFU_Mask;
      VLE:         vfu = VFU_Load;
      VSE:         vfu = VFU_Store;
      default:     vfu = VFU_Lane;
    endcase
  endfunction

  always_comb begin
    req_vfu = vfu(req_i.op);
    // Store unit and mask unit share one queue
    struct_hazard = ((req_vfu == VFU_Store) && (|pe_running_i[NrLanes + OffsetMask])) ||
                    ((req_vfu == VFU_Mask) && (|pe_running_i[NrLanes + OffsetStore]));
    // No acceptance while a request is on the way, PE ready flags lag one cycle
    accept  = (state_q == IDLE) && req_valid_i && !pe_req_valid_o && (&pe_ready_i) &&
              !full_i && !struct_hazard;
    wait_op = (req_vfu inside {VFU_Load, VFU_Store}) || !req_i.use_vd;
    mem_op  = pe_req_o.vfu inside {VFU_Load, VFU_Store};

    // PEs that run the new id
    alloc_pe_mask_o = '0;
    case (req_vfu)
      VFU_Load:  alloc_pe_mask_o[NrLanes + OffsetLoad]  = 1'b1;
      VFU_Store: alloc_pe_mask_o[NrLanes + OffsetStore] = 1'b1;
      VFU_Mask:  alloc_pe_mask_o[NrLanes + OffsetMask]  = 1'b1;
      default:   alloc_pe_mask_o[NrLanes-1:0]           = '1;
    endcase
    // Masked ops also need the mask unit
    if (!req_i.vm) begin
      alloc_pe_mask_o[NrLanes + OffsetMask] = 1'b1;
    end

    alloc_o        = accept;
    issue_o        = accept;
    state_d        = state_q;
    req_ready_o    = accept && !wait_op;
    resp_o         = '0;
    resp_valid_o   = 1'b0;
    pe_req_valid_d = accept;

    // Held request follows retirements
    pe_req_d               = pe_req_o;
    pe_req_d.vinsn_running = running_next_i;
    pe_req_d.hazard_vs1    = pe_req_o.hazard_vs1 & running_next_i;
    pe_req_d.hazard_vs2    = pe_req_o.hazard_vs2 & running_next_i;
    pe_req_d.hazard_vm     = pe_req_o.hazard_vm & running_next_i;
    pe_req_d.hazard_vd     = pe_req_o.hazard_vd & running_next_i;

    if (accept) begin
      pe_req_d = '{
        id:            next_id_i,
        op:            req_i.op,
        vfu:           req_vfu,
        vm:            req_i.vm,
        vl:            req_i.vl,
        eew:           req_i.eew,
        scalar_op:     req_i.scalar_op,
        vinsn_running: running_next_i,
        hazard_vs1:    haz_vs1_i,
        hazard_vs2:    haz_vs2_i,
        hazard_vm:     haz_vm_i,
        hazard_vd:     haz_vd_i
      };
      // Dispatcher keeps the request up until the response
      if (wait_op) begin
        state_d = WAIT;
      end
    end

    // Memory ops end on the address ack, others on the lane 0 result
    if ((state_q == WAIT) && (mem_op ? addr_ack_i : scalar_valid_i)) begin
      state_d      = IDLE;
      req_ready_o  = 1'b1;
      resp_valid_o = 1'b1;
      resp_o.resp  = mem_op ? '0 : scalar_i;
      resp_o.error = mem_op && addr_error_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= IDLE;
      pe_req_valid_o <= 1'b0;
    end else begin
      state_q        <= state_d;
      pe_req_valid_o <= pe_req_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    pe_req_o <= pe_req_d;
  end

  // Address acks only come back while a load or store waits for them
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    addr_ack_i |-> (state_q == WAIT) && mem_op);

endmodule

`default_nettype wire

/* design/vfu_exec.sv */
// Behavioural PE model, one queue slot plus a datapath that runs vl cycles per instruction
`timescale 1ns/1ps
`default_nettype none

module vfu_exec import vseq_isa_pkg::*; import vseq_uarch_pkg::*; #(
  parameter int unsigned NrPEs = 5,
  parameter int unsigned PeIdx = 0
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  pe_req_t                       pe_req_i,
  input  logic                          pe_req_valid_i,
  input  logic [NrPEs-1:0][NrVInsn-1:0] running_i,
  output logic                          ready_o,
  output pe_resp_t                      pe_resp_o,
  output elen_t                         scalar_o,
  output logic                          scalar_valid_o
);

  pe_req_t            q_req_q;
  logic               q_valid_q;
  logic [NrVInsn-1:0] q_haz_q;
  logic               ex_busy_q;
  vid_t               ex_id_q;
  logic               ex_scalar_q;
  logic [7:0]         ex_vl_q, ex_cnt_q;
  logic [NrVInsn-1:0] running_any;
  logic               take, start, ex_done;

  always_comb begin
    running_any = '0;
    for (int unsigned pe = 0; pe < NrPEs; pe++) begin
      running_any |= running_i[pe];
    end
  end

  // Only requests whose id was placed on this PE
  assign take    = pe_req_valid_i && running_i[PeIdx][pe_req_i.id];
  assign ex_done = ex_busy_q && (ex_cnt_q <= 8'd1);
  // Queue moves on once its hazards retired and the datapath frees up
  assign start   = q_valid_q && !(|(q_haz_q & running_any)) && (!ex_busy_q || ex_done);

  assign ready_o              = !q_valid_q;
  assign pe_resp_o.vinsn_done = ex_done ? (NrVInsn'(1) << ex_id_q) : '0;
  assign scalar_valid_o       = ex_done && ex_scalar_q;
  assign scalar_o             = elen_t'(ex_vl_q);  // Reduction result stand-in

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      q_valid_q <= 1'b0;
      ex_busy_q <= 1'b0;
    end else begin
      if (start) begin
        q_valid_q <= 1'b0;
      end
      if (take) begin
        q_valid_q <= 1'b1;
      end
      if (start) begin
        ex_busy_q <= 1'b1;
      end else if (ex_done) begin
        ex_busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    // Retired ids leave the mask before they can be handed out again
    q_haz_q <= q_haz_q & running_any;
    if (take) begin
      q_req_q <= pe_req_i;
      q_haz_q <= pe_req_i.hazard_vs1 | pe_req_i.hazard_vs2 |
                 pe_req_i.hazard_vm | pe_req_i.hazard_vd;
    end
    if (start) begin
      ex_id_q     <= q_req_q.id;
      ex_scalar_q <= (q_req_q.op == VREDSUM);
      ex_vl_q     <= q_req_q.vl;
      ex_cnt_q    <= q_req_q.vl;
    end else if (ex_busy_q) begin
      ex_cnt_q <= ex_cnt_q - 8'd1;
    end
  end

  // Sequencer waits for ready, so a new request never lands on a full slot
  assert property (@(posedge clk_i) disable iff (!rst_ni) take |-> !q_valid_q);

endmodule

`default_nettype wire

/* design/addr_check.sv */
// Address translation stand-in that acks loads and stores after a fixed delay and flags misalignment
`timescale 1ns/1ps
`default_nettype none

module addr_check import vseq_isa_pkg::*; import vseq_uarch_pkg::*; #(
  parameter int unsigned AddrAckDelay = 2
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  pe_req_t pe_req_i,
  input  logic    pe_req_valid_i,
  output logic    ack_o,
  output logic    error_o
);

  logic [AddrAckDelay-1:0] ack_q, err_q;
  logic                    mem_req, misaligned;

  // Base must be a multiple of the element size in bytes
  always_comb begin
    case (pe_req_i.eew)
      EW16:    misaligned = pe_req_i.scalar_op[0];
      EW32:    misaligned = |pe_req_i.scalar_op[1:0];
      EW64:    misaligned = |pe_req_i.scalar_op[2:0];
      default: misaligned = 1'b0;
    endcase
  end

  assign mem_req = pe_req_valid_i && (pe_req_i.vfu inside {VFU_Load, VFU_Store});
  assign ack_o   = ack_q[AddrAckDelay-1];
  assign error_o = err_q[AddrAckDelay-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= '0;
    end else begin
      ack_q <= (ack_q << 1) | AddrAckDelay'(mem_req);
    end
  end

  always_ff @(posedge clk_i) begin
    err_q <= (err_q << 1) | AddrAckDelay'(misaligned);
  end

endmodule

`default_nettype wire

/* design/vseq_top.sv */
// Sequencer subsystem top, wires the sequencer, id pool, scoreboard, PEs and address checker
`timescale 1ns/1ps
`default_nettype none

module vseq_top import vseq_isa_pkg::*; import vseq_uarch_pkg::*; #(
  parameter int unsigned NrLanes      = 2,
  parameter int unsigned NrPEs        = NrLanes + 3,
  parameter int unsigned AddrAckDelay = 2
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  vseq_req_t          req_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  output vseq_resp_t         resp_o,
  output logic               resp_valid_o,
  output logic               idle_o,
  output logic [NrVInsn-1:0] vinsn_done_o
);

  pe_req_t                       pe_req;
  logic                          pe_req_valid;
  logic [NrPEs-1:0]              pe_ready;
  pe_resp_t [NrPEs-1:0]          pe_resp;
  elen_t [NrPEs-1:0]             pe_scalar;
  logic [NrPEs-1:0]              pe_scalar_valid;
  vid_t                          next_id;
  logic                          full, alloc, issue, addr_ack, addr_error;
  logic [NrPEs-1:0]              alloc_pe_mask;
  logic [NrVInsn-1:0]            running, running_next;
  logic [NrPEs-1:0][NrVInsn-1:0] pe_running;
  logic [NrVInsn-1:0]            haz_vs1, haz_vs2, haz_vm, haz_vd;

  assign idle_o = ~|running;

  vseq_sequencer #(.NrLanes(NrLanes), .NrPEs(NrPEs)) i_sequencer (
    .clk_i, .rst_ni, .req_i, .req_valid_i, .req_ready_o, .resp_o, .resp_valid_o,
    .pe_ready_i(pe_ready), .next_id_i(next_id), .full_i(full),
    .pe_running_i(pe_running), .running_next_i(running_next),
    .haz_vs1_i(haz_vs1), .haz_vs2_i(haz_vs2), .haz_vm_i(haz_vm), .haz_vd_i(haz_vd),
    .addr_ack_i(addr_ack), .addr_error_i(addr_error),
    // Only lane 0 returns scalar results
    .scalar_i(pe_scalar[0]), .scalar_valid_i(pe_scalar_valid[0]),
    .alloc_o(alloc), .alloc_pe_mask_o(alloc_pe_mask), .issue_o(issue),
    .pe_req_o(pe_req), .pe_req_valid_o(pe_req_valid)
  );

  vinsn_id_alloc #(.NrPEs(NrPEs)) i_id_alloc (
    .clk_i, .rst_ni, .alloc_i(alloc), .alloc_id_i(next_id), .alloc_pe_mask_i(alloc_pe_mask),
    .pe_resp_i(pe_resp), .next_id_o(next_id), .full_o(full), .running_o(running),
    .running_next_o(running_next), .pe_running_o(pe_running), .retired_o(vinsn_done_o)
  );

  vreg_scoreboard i_scoreboard (
    .clk_i, .rst_ni, .issue_i(issue), .issue_id_i(next_id), .req_i, .running_i(running_next),
    .haz_vs1_o(haz_vs1), .haz_vs2_o(haz_vs2), .haz_vm_o(haz_vm), .haz_vd_o(haz_vd)
  );

  // Lanes first, then load, store and mask units
  for (genvar pe = 0; pe < NrPEs; pe++) begin : gen_pe
    vfu_exec #(.NrPEs(NrPEs), .PeIdx(pe)) i_vfu (
      .clk_i, .rst_ni, .pe_req_i(pe_req), .pe_req_valid_i(pe_req_valid),
      .running_i(pe_running), .ready_o(pe_ready[pe]), .pe_resp_o(pe_resp[pe]),
      .scalar_o(pe_scalar[pe]), .scalar_valid_o(pe_scalar_valid[pe])
    );
  end

  addr_check #(.AddrAckDelay(AddrAckDelay)) i_addr_check (
    .clk_i, .rst_ni, .pe_req_i(pe_req), .pe_req_valid_i(pe_req_valid),
    .ack_o(addr_ack), .error_o(addr_error)
  );

endmodule

`default_nettype wire

/* include/vseq_tb_vectors.svh */
// Request table with expected responses, included by the testbench after it imports vseq_isa_pkg
`ifndef VSEQ_TB_VECTORS_SVH
`define VSEQ_TB_VECTORS_SVH

// One dispatcher request and what it should return
typedef struct packed {
  vseq_req_t req;
  logic      has_resp;  // Memory ops and ops without vd
  elen_t     resp;
  logic      error;
} tb_vec_t;

localparam int unsigned TbNumVectors = 18;
// Longest vl in the table, sizes the watchdog
localparam int unsigned TbMaxVl      = 40;

// Request fields: op, vm, vs1, use_vs1, vs2, use_vs2, vd, use_vd, scalar_op, eew, vl
localparam tb_vec_t TbVectors [TbNumVectors] = '{
  // Loads and stores, aligned then misaligned
  '{'{VLE, '1, 5'd0, '0, 5'd0, '0, 5'd4, '1, 32'h1000, EW32, 8'd8}, '1, 32'd0, '0},
  '{'{VLE, '1, 5'd0, '0, 5'd0, '0, 5'd5, '1, 32'h1002, EW32, 8'd4}, '1, 32'd0, '1},
  '{'{VSE, '1, 5'd4, '1, 5'd0, '0, 5'd0, '0, 32'h1006, EW16, 8'd8}, '1, 32'd0, '0},
  '{'{VSE, '1, 5'd5, '1, 5'd0, '0, 5'd0, '0, 32'h1003, EW64, 8'd4}, '1, 32'd0, '1},
  // Reduction reading the first load
  '{'{VREDSUM, '1, 5'd0, '0, 5'd4, '1, 5'd0, '0, 32'd0, EW32, 8'd12}, '1, 32'd12, '0},
  // RAW on v3, then WAW on v6 with the second writer in the mask unit
  '{'{VADD, '1, 5'd1, '1, 5'd2, '1, 5'd3, '1, 32'd0, EW32, 8'd16}, '0, 32'd0, '0},
  '{'{VMUL, '1, 5'd3, '1, 5'd2, '1, 5'd6, '1, 32'd0, EW32, 8'd8}, '0, 32'd0, '0},
  '{'{VMAND, '1, 5'd1, '1, 5'd2, '1, 5'd6, '1, 32'd0, EW32, 8'd2}, '0, 32'd0, '0},
  // Store behind a mask unit op, then behind a masked lane op
  '{'{VMAND, '1, 5'd0, '1, 5'd1, '1, 5'd7, '1, 32'd0, EW8, 8'd20}, '0, 32'd0, '0},
  '{'{VSE, '1, 5'd7, '1, 5'd0, '0, 5'd0, '0, 32'h2000, EW8, 8'd8}, '1, 32'd0, '0},
  '{'{VADD, '0, 5'd1, '1, 5'd2, '1, 5'd8, '1, 32'd0, EW32, 8'd10}, '0, 32'd0, '0},
  '{'{VSE, '1, 5'd8, '1, 5'd0, '0, 5'd0, '0, 32'h2004, EW32, 8'd8}, '1, 32'd0, '0},
  // Five long independent lane ops against a pool of four ids
  '{'{VADD, '1, 5'd20, '1, 5'd25, '1, 5'd10, '1, 32'd0, EW32, 8'd40}, '0, 32'd0, '0},
  '{'{VADD, '1, 5'd21, '1, 5'd25, '1, 5'd11, '1, 32'd0, EW32, 8'd40}, '0, 32'd0, '0},
  '{'{VADD, '1, 5'd22, '1, 5'd25, '1, 5'd12, '1, 32'd0, EW32, 8'd40}, '0, 32'd0, '0},
  '{'{VADD, '1, 5'd23, '1, 5'd25, '1, 5'd13, '1, 32'd0, EW32, 8'd40}, '0, 32'd0, '0},
  '{'{VADD, '1, 5'd24, '1, 5'd25, '1, 5'd14, '1, 32'd0, EW32, 8'd40}, '0, 32'd0, '0},
  '{'{VREDSUM, '1, 5'd0, '0, 5'd10, '1, 5'd0, '0, 32'd0, EW32, 8'd3}, '1, 32'd3, '0}
};

`endif

/* tests/vseq_tb.sv */
// Table-driven testbench for vseq_top, checks responses, hazard ordering and id pool limits
`timescale 1ns/1ps
`default_nettype none

module vseq_tb import vseq_isa_pkg::*; import vseq_uarch_pkg::*; ();

  `include "vseq_tb_vectors.svh"

  localparam int unsigned WatchdogCycles = TbNumVectors * (TbMaxVl + 20) + 100;

  logic               clk_i, rst_ni, req_valid_i, req_ready_o, resp_valid_o, idle_o;
  vseq_req_t          req_i;
  vseq_resp_t         resp_o;
  logic [NrVInsn-1:0] vinsn_done_o;

  // Values sampled at the falling edge of the last cycle
  logic               ready_s, resp_v_s, idle_s;
  vseq_resp_t         resp_s;
  logic [NrVInsn-1:0] done_s, busy, busy_prev;
  int                 cycle, errors, done_cnt;
  vid_t               ent_id [TbNumVectors];
  logic               ent_live [TbNumVectors];
  int                 ent_done_cyc [TbNumVectors];

  vseq_top #(.NrLanes(2), .AddrAckDelay(2)) dut_i (
    .clk_i, .rst_ni, .req_i, .req_valid_i, .req_ready_o, .resp_o, .resp_valid_o,
    .idle_o, .vinsn_done_o
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Watchdog sized from the table length and the longest vl
  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the run did not finish", WatchdogCycles);
    $display("tests failed");
    $finish;
  end

  function automatic vid_t lowest_free(logic [NrVInsn-1:0] used);
    vid_t id;
    id = '0;
    for (int i = NrVInsn - 1; i >= 0; i--) begin
      if (!used[i]) id = vid_t'(i);
    end
    return id;
  endfunction

  // One clock, sample outputs at the falling edge, then move to the drive point
  task automatic step_cycle();
    @(negedge clk_i);
    cycle++;
    ready_s  = req_ready_o;
    resp_v_s = resp_valid_o;
    resp_s   = resp_o;
    idle_s   = idle_o;
    done_s   = vinsn_done_o;
    if (|done_s) done_cnt++;
    for (int k = 0; k < TbNumVectors; k++) begin
      if (ent_live[k] && done_s[ent_id[k]]) begin
        ent_done_cyc[k] = cycle;
        ent_live[k]     = 1'b0;
      end
    end
    busy_prev = busy;
    busy      = busy & ~done_s;
    @(posedge clk_i);
    #1;
  endtask

  // Cycle with nothing driven, no response may appear
  task automatic quiet_cycle();
    step_cycle();
    if (resp_v_s) begin
      errors++;
      $display("Unexpected response while no request was pending at cycle %0d", cycle);
    end
  endtask

  task automatic wait_idle();
    do quiet_cycle(); while (!idle_s);
    busy = '0;
  endtask

  task automatic apply_vector(int k, ref int snap);
    tb_vec_t v;
    v           = TbVectors[k];
    req_i       = v.req;
    req_valid_i = 1'b1;
    do begin
      step_cycle();
      if (resp_v_s && !(ready_s && v.has_resp)) begin
        errors++;
        $display("Response arrived before entry %0d was accepted", k);
      end
    end while (!ready_s);
    req_valid_i = 1'b0;
    req_i       = '0;
    if (v.has_resp) begin
      if (!resp_v_s) begin
        errors++;
        $display("Fail resp_valid_o entry %0d exp %h got %h", k, 1'b1, resp_v_s);
      end else begin
        if (resp_s.resp != v.resp) begin
          errors++;
          $display("Fail resp_o.resp entry %0d exp %h got %h", k, v.resp, resp_s.resp);
        end
        if (resp_s.error != v.error) begin
          errors++;
          $display("Fail resp_o.error entry %0d exp %h got %h", k, v.error, resp_s.error);
        end
      end
    end else begin
      // Op took the lowest id that was not running
      ent_id[k]   = lowest_free(busy_prev);
      ent_live[k] = 1'b1;
      busy[ent_id[k]] = 1'b1;
    end
    // Store after a mask user, and fifth op of the long group
    if ((k == 9 || k == 11 || k == 16) && done_cnt <= snap) begin
      errors++;
      $display("Entry %0d was accepted before any earlier id retired", k);
    end
  endtask

  initial begin
    int snap;
    int gap;
    void'($urandom(32'h6ed1));
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    busy        = '0;
    cycle       = 0;
    errors      = 0;
    done_cnt    = 0;
    snap        = 0;
    for (int k = 0; k < TbNumVectors; k++) begin
      ent_live[k]     = 1'b0;
      ent_done_cyc[k] = 0;
      ent_id[k]       = '0;
    end
    repeat (8) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    step_cycle();
    if (!idle_s || resp_v_s || |done_s) begin
      errors++;
      $display("Outputs not at rest after reset");
    end

    for (int k = 0; k < TbNumVectors; k++) begin
      // Sections that need a known id state start from idle
      if (k == 5 || k == 8 || k == 10 || k == 12) wait_idle();
      if (k == 8) begin
        if (ent_done_cyc[6] <= ent_done_cyc[5]) begin
          errors++;
          $display("RAW consumer retired before its producer");
        end
        if (ent_done_cyc[7] <= ent_done_cyc[6]) begin
          errors++;
          $display("WAW second writer retired before the first");
        end
      end
      if (k == 8 || k == 10 || k == 12) snap = done_cnt;
      apply_vector(k, snap);
      gap = $urandom % 4;
      repeat (gap) quiet_cycle();
    end

    wait_idle();
    // Drained, nothing more may come out
    repeat (50) begin
      quiet_cycle();
      if (|done_s || !idle_s) begin
        errors++;
        $display("Activity after the table drained at cycle %0d", cycle);
      end
    end

    $display("%0d errors after %0d cycles", errors, cycle);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
design/vseq_isa_pkg.sv
design/vseq_uarch_pkg.sv
design/vinsn_id_alloc.sv
design/vreg_scoreboard.sv
design/vseq_sequencer.sv
design/vfu_exec.sv
design/addr_check.sv
design/vseq_top.sv
tests/vseq_tb.sv

/* run.sh */
#!/bin/sh
# Build the sequencer testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module vseq_tb -o vseq_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/vseq_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
